// File: src/rdp_pkg.sv
// Geometry, register map and shared structs of the full-rate read datapath
// Two read DQS groups of 8 DQ each, AFI side clocked by pll_afi_clk only
`default_nettype none

package rdp_pkg;

	// ****************************************
	// Memory and AFI geometry
	// ****************************************

	localparam int NUM_GROUPS = 2;
	localparam int GROUP_DQ_WIDTH = 8;
	localparam int MEM_DQ_WIDTH = NUM_GROUPS * GROUP_DQ_WIDTH;
	// Two time slots of every DQ bit, same width as the DDIO input bus
	localparam int AFI_DATA_WIDTH = 2 * MEM_DQ_WIDTH;

	// Read latency shifter and the legal window for the latency count
	localparam int MAX_READ_LATENCY = 16;
	localparam int MIN_READ_LATENCY = 2;
	localparam int LAT_WIDTH = 5;

	// Resynchronization FIFO, one per group
	localparam int READ_FIFO_DEPTH = 8;
	localparam int READ_FIFO_ADDR_WIDTH = 3;

	// Valid prediction token shifter
	localparam int VFIFO_ADDR_WIDTH = 3;
	localparam int QVLD_EXTRA_FLOP_STAGES = 1;
	localparam int QVLD_SHIFTER_LENGTH = (2 ** VFIFO_ADDR_WIDTH) + QVLD_EXTRA_FLOP_STAGES;
	// One extra bit so the write index can reach the top of the shifter
	localparam int QVLD_IDX_WIDTH = VFIFO_ADDR_WIDTH + 1;

	// Termination window, counted in AFI cycles from the read request
	localparam int MEM_T_RL = 6;
	localparam int OCT_ON_DELAY = (MEM_T_RL > 4) ? ((MEM_T_RL - 4) / 2) : 0;
	localparam int OCT_OFF_DELAY = (MEM_T_RL + 6) / 2;

	// ****************************************
	// Calibration register map
	// ****************************************

	localparam int APB_ADDR_WIDTH = 4;
	localparam int APB_DATA_WIDTH = 32;

	localparam logic [APB_ADDR_WIDTH-1:0] ADDR_READ_LATENCY = 4'h0;
	localparam logic [APB_ADDR_WIDTH-1:0] ADDR_VFIFO_INCR = 4'h4;
	localparam logic [APB_ADDR_WIDTH-1:0] ADDR_FIFO_RESET = 4'h8;

	// APB request as seen by the slave
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [APB_ADDR_WIDTH-1:0] paddr;
		logic [APB_DATA_WIDTH-1:0] pwdata;
	} apb_req_t;

	// APB response, valid in the access cycle
	typedef struct packed {
		logic [APB_DATA_WIDTH-1:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	// Calibration controls fanned out to the execute and result stages
	typedef struct packed {
		logic [LAT_WIDTH-1:0] read_latency;
		logic [NUM_GROUPS-1:0] vfifo_incr;
		logic [NUM_GROUPS-1:0] fifo_reset;
	} calib_ctrl_t;

endpackage

`default_nettype wire

// File: src/rdp_calib_regs.sv
// APB slave with zero wait states; expects a setup cycle before every access
// Out-of-range latency writes are dropped and flagged with pslverr
`timescale 1ns/10ps
`default_nettype none

module rdp_calib_regs (
	input  wire                  pll_afi_clk,
	input  wire                  reset_n_afi_clk,
	input  rdp_pkg::apb_req_t    apb_req_i,
	output rdp_pkg::apb_rsp_t    apb_rsp_o,
	output rdp_pkg::calib_ctrl_t calib_ctrl_o
);

	// Access phase of a transfer
	logic access;
	// One-hot address hits
	logic hit_latency;
	logic hit_incr;
	logic hit_reset;
	logic hit_any;
	// Write data lies in the accepted latency window
	logic lat_in_range;

	logic [rdp_pkg::LAT_WIDTH-1:0] read_latency;
	logic [rdp_pkg::NUM_GROUPS-1:0] vfifo_incr;
	logic [rdp_pkg::NUM_GROUPS-1:0] fifo_reset;

	// ****************************************
	// Address decode
	// ****************************************

	assign access = apb_req_i.psel & apb_req_i.penable;

	assign hit_latency = (apb_req_i.paddr == rdp_pkg::ADDR_READ_LATENCY);
	assign hit_incr = (apb_req_i.paddr == rdp_pkg::ADDR_VFIFO_INCR);
	assign hit_reset = (apb_req_i.paddr == rdp_pkg::ADDR_FIFO_RESET);
	assign hit_any = hit_latency | hit_incr | hit_reset;

	assign lat_in_range = (apb_req_i.pwdata >= rdp_pkg::MIN_READ_LATENCY) &&
		(apb_req_i.pwdata <= rdp_pkg::MAX_READ_LATENCY);

	// The response is combinational and lands in the access cycle itself
	always_comb
	begin
		apb_rsp_o.pready = access;
		apb_rsp_o.pslverr = access &
			(~hit_any | (apb_req_i.pwrite & hit_latency & ~lat_in_range));
		// Only the latency register reads back, command registers read as zero
		if (hit_latency & ~apb_req_i.pwrite)
			apb_rsp_o.prdata = {{(rdp_pkg::APB_DATA_WIDTH-rdp_pkg::LAT_WIDTH){1'b0}},
				read_latency};
		else
			apb_rsp_o.prdata = '0;
	end

	// ****************************************
	// Latency register and command pulses
	// ****************************************

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (~reset_n_afi_clk)
		begin
			read_latency <= rdp_pkg::LAT_WIDTH'(rdp_pkg::MIN_READ_LATENCY);
			vfifo_incr <= '0;
			fifo_reset <= '0;
		end
		else
		begin
			// New latency applies from the edge that closes the access
			if (access & apb_req_i.pwrite & hit_latency & lat_in_range)
				read_latency <= apb_req_i.pwdata[rdp_pkg::LAT_WIDTH-1:0];

			// Commands last one cycle, one bit per DQS group
			if (access & apb_req_i.pwrite & hit_incr)
				vfifo_incr <= apb_req_i.pwdata[rdp_pkg::NUM_GROUPS-1:0];
			else
				vfifo_incr <= '0;

			if (access & apb_req_i.pwrite & hit_reset)
				fifo_reset <= apb_req_i.pwdata[rdp_pkg::NUM_GROUPS-1:0];
			else
				fifo_reset <= '0;
		end
	end

	assign calib_ctrl_o.read_latency = read_latency;
	assign calib_ctrl_o.vfifo_incr = vfifo_incr;
	assign calib_ctrl_o.fifo_reset = fifo_reset;

	// An access must follow a setup cycle of the same transfer
	a_apb_setup_before_access: assert property (
		@(posedge pll_afi_clk) disable iff (~reset_n_afi_clk)
		apb_req_i.penable |-> apb_req_i.psel &&
			$past(apb_req_i.psel && !apb_req_i.penable)
	);

endmodule

`default_nettype wire

// File: src/rdp_latency_pipe.sv
// Full-rate read latency shifter, one request bit per AFI cycle
// The latency count must stay within MIN_READ_LATENCY..MAX_READ_LATENCY
`timescale 1ns/10ps
`default_nettype none

module rdp_latency_pipe (
	input  wire                          pll_afi_clk,
	input  wire                          reset_n_afi_clk,
	input  wire                          afi_rdata_en_full_i,
	input  wire [rdp_pkg::LAT_WIDTH-1:0] read_latency_i,
	output logic                         read_enable_o,
	output logic                         afi_rdata_valid_o,
	output logic                         force_oct_off_o
);

	// Bit k is high in the cycle after edge E+k for a request sampled at E
	logic [rdp_pkg::MAX_READ_LATENCY:0] lat_shift;
	// Short request history that frames the termination window
	logic [rdp_pkg::OCT_OFF_DELAY:0] oct_hist;

	// ****************************************
	// Read latency shifter
	// ****************************************

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (~reset_n_afi_clk)
			lat_shift <= '0;
		else
			lat_shift <= {lat_shift[rdp_pkg::MAX_READ_LATENCY-1:0], afi_rdata_en_full_i};
	end

	// The tap at the calibrated latency pops the read FIFO of every group
	assign read_enable_o = lat_shift[read_latency_i];

	// Valid trails the pop by one edge, the same edge that registers the FIFO data
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (~reset_n_afi_clk)
			afi_rdata_valid_o <= 1'b0;
		else
			afi_rdata_valid_o <= read_enable_o;
	end

	// ****************************************
	// Termination force-off window
	// ****************************************

	// Termination stays forced off unless a read burst is due on the bus.
	// The window opens OCT_ON_DELAY cycles after the request and closes after
	// OCT_OFF_DELAY cycles, both measured from the first history stage
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (~reset_n_afi_clk)
		begin
			oct_hist <= '0;
			force_oct_off_o <= 1'b1;
		end
		else
		begin
			oct_hist <= {oct_hist[rdp_pkg::OCT_OFF_DELAY-1:0], afi_rdata_en_full_i};
			force_oct_off_o <= ~(|oct_hist[rdp_pkg::OCT_OFF_DELAY:rdp_pkg::OCT_ON_DELAY]);
		end
	end

	// The register stage upstream must never hand over a latency outside the shifter
	a_latency_in_range: assert property (
		@(posedge pll_afi_clk) disable iff (~reset_n_afi_clk)
		(read_latency_i >= rdp_pkg::MIN_READ_LATENCY) &&
			(read_latency_i <= rdp_pkg::MAX_READ_LATENCY)
	);

endmodule

`default_nettype wire

// File: src/rdp_valid_predict.sv
// Full-rate DQS-enable prediction, one token shifter per read group
// Write address starts at zero and wraps modulo 8 on increment pulses
`timescale 1ns/10ps
`default_nettype none

module rdp_valid_predict (
	input  wire                           pll_afi_clk,
	input  wire                           reset_n_afi_clk,
	input  wire                           afi_rdata_en_full_i,
	input  wire [rdp_pkg::NUM_GROUPS-1:0] vfifo_incr_i,
	output logic [rdp_pkg::NUM_GROUPS-1:0] dqs_enable_ctrl_o
);

	// Request token, registered once before it enters the shifters
	logic token_r;
	// Per-group write address moved by the sequencer
	logic [rdp_pkg::VFIFO_ADDR_WIDTH-1:0] wr_addr [rdp_pkg::NUM_GROUPS];
	// Shifter position the token lands in, address plus fixed stages
	logic [rdp_pkg::QVLD_IDX_WIDTH-1:0] wr_idx [rdp_pkg::NUM_GROUPS];
	logic [rdp_pkg::QVLD_SHIFTER_LENGTH-1:0] qvld_shift [rdp_pkg::NUM_GROUPS];

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (~reset_n_afi_clk)
			token_r <= 1'b0;
		else
			token_r <= afi_rdata_en_full_i;
	end

	always_comb
	begin
		for (int g = 0; g < rdp_pkg::NUM_GROUPS; g++)
			wr_idx[g] = {1'b0, wr_addr[g]} +
				rdp_pkg::QVLD_IDX_WIDTH'(rdp_pkg::QVLD_EXTRA_FLOP_STAGES);
	end

	// Each increment delays the predicted window of its group by one cycle.
	// The shifter drops one position per cycle toward bit 0, so a token written at
	// position A+1 reaches the output A+1 cycles later
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (~reset_n_afi_clk)
		begin
			for (int g = 0; g < rdp_pkg::NUM_GROUPS; g++)
			begin
				wr_addr[g] <= '0;
				qvld_shift[g] <= '0;
			end
		end
		else
		begin
			for (int g = 0; g < rdp_pkg::NUM_GROUPS; g++)
			begin
				if (vfifo_incr_i[g])
					wr_addr[g] <= wr_addr[g] + 1'b1;
				qvld_shift[g] <= {1'b0, qvld_shift[g][rdp_pkg::QVLD_SHIFTER_LENGTH-1:1]};
				// The write wins over the shift for the addressed position
				qvld_shift[g][wr_idx[g]] <= token_r;
			end
		end
	end

	always_comb
	begin
		for (int g = 0; g < rdp_pkg::NUM_GROUPS; g++)
			dqs_enable_ctrl_o[g] = qvld_shift[g][0];
	end

endmodule

`default_nettype wire

// File: src/rdp_read_fifo.sv
// Resync FIFOs, one per group, writing one DDIO word every cycle without flow control
// Unread words are overwritten once the write pointer laps the read pointer
`timescale 1ns/10ps
`default_nettype none

module rdp_read_fifo (
	input  wire                               pll_afi_clk,
	input  wire                               reset_n_afi_clk,
	input  wire [rdp_pkg::AFI_DATA_WIDTH-1:0] ddio_phy_dq_i,
	input  wire [rdp_pkg::NUM_GROUPS-1:0]     fifo_reset_i,
	input  wire                               read_enable_i,
	output logic [rdp_pkg::AFI_DATA_WIDTH-1:0] afi_rdata_o
);

	// Flop memory per group, each word is {T1 byte, T0 byte}
	logic [2*rdp_pkg::GROUP_DQ_WIDTH-1:0] fifo_mem [rdp_pkg::NUM_GROUPS][rdp_pkg::READ_FIFO_DEPTH];
	logic [rdp_pkg::READ_FIFO_ADDR_WIDTH-1:0] wr_ptr [rdp_pkg::NUM_GROUPS];
	logic [rdp_pkg::READ_FIFO_ADDR_WIDTH-1:0] rd_ptr [rdp_pkg::NUM_GROUPS];
	// Registered read words, still in group order
	logic [2*rdp_pkg::GROUP_DQ_WIDTH-1:0] rd_word [rdp_pkg::NUM_GROUPS];

	// ****************************************
	// Pointers
	// ****************************************

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (~reset_n_afi_clk)
		begin
			for (int g = 0; g < rdp_pkg::NUM_GROUPS; g++)
			begin
				wr_ptr[g] <= '0;
				rd_ptr[g] <= '0;
			end
		end
		else
		begin
			for (int g = 0; g < rdp_pkg::NUM_GROUPS; g++)
			begin
				// A reset command realigns both sides of the group to slot 0
				if (fifo_reset_i[g])
				begin
					wr_ptr[g] <= '0;
					rd_ptr[g] <= '0;
				end
				else
				begin
					wr_ptr[g] <= wr_ptr[g] + 1'b1;
					if (read_enable_i)
						rd_ptr[g] <= rd_ptr[g] + 1'b1;
				end
			end
		end
	end

	// ****************************************
	// Storage and read register
	// ****************************************

	always_ff @(posedge pll_afi_clk)
	begin
		for (int g = 0; g < rdp_pkg::NUM_GROUPS; g++)
		begin
			fifo_mem[g][wr_ptr[g]] <= ddio_phy_dq_i[g*2*rdp_pkg::GROUP_DQ_WIDTH +:
				2*rdp_pkg::GROUP_DQ_WIDTH];
			// Reads see the slot contents from before this edge's write
			if (read_enable_i)
				rd_word[g] <= fifo_mem[g][rd_ptr[g]];
		end
	end

	// Group order in, time-slot order out: {G1T1, G0T1, G1T0, G0T0}
	always_comb
	begin
		for (int g = 0; g < rdp_pkg::NUM_GROUPS; g++)
			for (int t = 0; t < 2; t++)
				afi_rdata_o[t*rdp_pkg::MEM_DQ_WIDTH + g*rdp_pkg::GROUP_DQ_WIDTH +:
					rdp_pkg::GROUP_DQ_WIDTH] = rd_word[g][t*rdp_pkg::GROUP_DQ_WIDTH +:
					rdp_pkg::GROUP_DQ_WIDTH];
	end

	// The sequencer only resets a FIFO while no read is being released
	a_no_read_during_reset: assert property (
		@(posedge pll_afi_clk) disable iff (~reset_n_afi_clk)
		(|fifo_reset_i) |-> !read_enable_i
	);

endmodule

`default_nettype wire

// File: src/rdp_read_datapath.sv
// Full-rate DDR2 read datapath top, AFI clock domain only
// Calibration is driven over APB in place of a sequencer bus
`timescale 1ns/10ps
`default_nettype none

module rdp_read_datapath (
	input  wire                               pll_afi_clk,
	input  wire                               reset_n_afi_clk,
	input  rdp_pkg::apb_req_t                 apb_req_i,
	output rdp_pkg::apb_rsp_t                 apb_rsp_o,
	input  wire                               afi_rdata_en_full_i,
	input  wire [rdp_pkg::AFI_DATA_WIDTH-1:0] ddio_phy_dq_i,
	output logic [rdp_pkg::AFI_DATA_WIDTH-1:0] afi_rdata_o,
	output logic                              afi_rdata_valid_o,
	output logic [rdp_pkg::NUM_GROUPS-1:0]    dqs_enable_ctrl_o,
	output logic                              force_oct_off_o
);

	// Latency count and per-group command pulses
	rdp_pkg::calib_ctrl_t calib_ctrl;
	// Shared FIFO pop from the latency shifter
	logic read_enable;

	// Decode stage
	rdp_calib_regs u_calib_regs (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.apb_req_i       (apb_req_i),
		.apb_rsp_o       (apb_rsp_o),
		.calib_ctrl_o    (calib_ctrl)
	);

	// Execute stage, read latency and termination
	rdp_latency_pipe u_latency_pipe (
		.pll_afi_clk         (pll_afi_clk),
		.reset_n_afi_clk     (reset_n_afi_clk),
		.afi_rdata_en_full_i (afi_rdata_en_full_i),
		.read_latency_i      (calib_ctrl.read_latency),
		.read_enable_o       (read_enable),
		.afi_rdata_valid_o   (afi_rdata_valid_o),
		.force_oct_off_o     (force_oct_off_o)
	);

	// Execute stage, DQS-enable prediction
	rdp_valid_predict u_valid_predict (
		.pll_afi_clk         (pll_afi_clk),
		.reset_n_afi_clk     (reset_n_afi_clk),
		.afi_rdata_en_full_i (afi_rdata_en_full_i),
		.vfifo_incr_i        (calib_ctrl.vfifo_incr),
		.dqs_enable_ctrl_o   (dqs_enable_ctrl_o)
	);

	// Result stage
	rdp_read_fifo u_read_fifo (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.ddio_phy_dq_i   (ddio_phy_dq_i),
		.fifo_reset_i    (calib_ctrl.fifo_reset),
		.read_enable_i   (read_enable),
		.afi_rdata_o     (afi_rdata_o)
	);

endmodule

`default_nettype wire

// File: bench/tb_tests.svh
// Directed tests, included inside the testbench module
// Each test ends idle with no read in flight, so FIFO resets never meet a pop
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

// ****************************************
// Register helpers
// ****************************************

task automatic set_read_latency(input string name, input int lat);
	apb_write(name, rdp_pkg::ADDR_READ_LATENCY, lat, 1'b0);
	cur_lat = lat;
endtask

// The first word driven after this task returns lands in slot 0
task automatic reset_read_fifos(input string name,
	input logic [rdp_pkg::NUM_GROUPS-1:0] mask);
	apb_write(name, rdp_pkg::ADDR_FIFO_RESET, mask, 1'b0);
	fifo_base = dq_log.size();
	rd_count = 0;
endtask

task automatic step_vfifo(input string name, input logic [rdp_pkg::NUM_GROUPS-1:0] mask);
	apb_write(name, rdp_pkg::ADDR_VFIFO_INCR, mask, 1'b0);
	// The write address wraps after eight steps
	for (int g = 0; g < rdp_pkg::NUM_GROUPS; g++)
		if (mask[g])
			vfifo_addr[g] = (vfifo_addr[g] + 1) % (2 ** rdp_pkg::VFIFO_ADDR_WIDTH);
endtask

// ****************************************
// Tests
// ****************************************

task automatic reset_defaults;
	string name;
	name = "reset_defaults";
	idle_cycles(name, 2);
	// Idle bus, so no ready and no error
	check_apb_rsp(name, '0, apb_rsp_o, 1'b0);
	expect_bit({name, " valid"}, 1'b0, afi_rdata_valid_o);
	expect_dqs_enable({name, " dqs_enable"}, '0, dqs_enable_ctrl_o);
	expect_bit({name, " force_oct_off"}, 1'b1, force_oct_off_o);
	apb_read(name, rdp_pkg::ADDR_READ_LATENCY, rdp_pkg::MIN_READ_LATENCY, 1'b0);
	// Out of range write and unmapped read both flag an error
	apb_write(name, rdp_pkg::ADDR_READ_LATENCY, 17, 1'b1);
	apb_read(name, 4'hC, '0, 1'b1);
	apb_read(name, rdp_pkg::ADDR_READ_LATENCY, rdp_pkg::MIN_READ_LATENCY, 1'b0);
endtask

task automatic burst_at_latency(input int lat);
	string name;
	name = $sformatf("latency_burst_L%0d", lat);
	set_read_latency(name, lat);
	reset_read_fifos(name, 2'b11);
	repeat (4)
		drive_edge(name, 1'b1, '0);
	// Drain the whole latency shifter, a longer latency set next must find no request left
	idle_cycles(name, rdp_pkg::MAX_READ_LATENCY + 4);
endtask

task automatic latency_bursts;
	burst_at_latency(2);
	burst_at_latency(5);
	burst_at_latency(rdp_pkg::MAX_READ_LATENCY);
endtask

task automatic irregular_requests;
	string name;
	// Sent from the left, eleven requests so the slot index wraps
	logic [18:0] pattern;
	name = "irregular_requests";
	pattern = 19'b1011_0001_1101_0011_011;
	set_read_latency(name, 7);
	reset_read_fifos(name, 2'b11);
	for (int i = 18; i >= 0; i--)
		drive_edge(name, pattern[i], '0);
	idle_cycles(name, 11);
endtask

task automatic vfifo_steps;
	string name;
	name = "vfifo_steps";
	// Group 0 moves three cycles later, group 1 keeps address 0
	repeat (3)
		step_vfifo(name, 2'b01);
	drive_edge(name, 1'b1, '0);
	idle_cycles(name, 10);
endtask

task automatic oct_window;
	string name;
	name = "oct_window";
	idle_cycles(name, 4);
	// One isolated request opens and closes the termination window
	drive_edge(name, 1'b1, '0);
	idle_cycles(name, 12);
endtask

`endif

// File: bench/tb_read_datapath.sv
// Directed testbench for the full-rate read datapath, stops at the first mismatch
// Expected values come from a log of the requests and DDIO words driven each edge
`timescale 1ns/10ps
`default_nettype none

module tb_read_datapath;

	localparam int CLK_HALF_NS = 10;
	// Driven cycles of the five tests, summed from their drive loops
	localparam int TEST_CYCLES = 177;
	localparam int WATCHDOG_NS = (TEST_CYCLES + 3) * 2 * CLK_HALF_NS + 2000;

	logic pll_afi_clk;
	logic reset_n_afi_clk;
	rdp_pkg::apb_req_t apb_req_i;
	rdp_pkg::apb_rsp_t apb_rsp_o;
	logic afi_rdata_en_full_i;
	logic [rdp_pkg::AFI_DATA_WIDTH-1:0] ddio_phy_dq_i;
	logic [rdp_pkg::AFI_DATA_WIDTH-1:0] afi_rdata_o;
	logic afi_rdata_valid_o;
	logic [rdp_pkg::NUM_GROUPS-1:0] dqs_enable_ctrl_o;
	logic force_oct_off_o;

	integer seed = 27;
	// One entry per driven edge, the index counts edges since reset release
	logic en_log [$];
	logic [rdp_pkg::AFI_DATA_WIDTH-1:0] dq_log [$];
	// Expected DUT state, updated by the tests as they program it
	int cur_lat = rdp_pkg::MIN_READ_LATENCY;
	int vfifo_addr [rdp_pkg::NUM_GROUPS];
	// Log index of the word that lands in slot 0 after the last FIFO reset
	int fifo_base = 0;
	int rd_count = 0;

	rdp_read_datapath u_rdp_read_datapath (
		.pll_afi_clk         (pll_afi_clk),
		.reset_n_afi_clk     (reset_n_afi_clk),
		.apb_req_i           (apb_req_i),
		.apb_rsp_o           (apb_rsp_o),
		.afi_rdata_en_full_i (afi_rdata_en_full_i),
		.ddio_phy_dq_i       (ddio_phy_dq_i),
		.afi_rdata_o         (afi_rdata_o),
		.afi_rdata_valid_o   (afi_rdata_valid_o),
		.dqs_enable_ctrl_o   (dqs_enable_ctrl_o),
		.force_oct_off_o     (force_oct_off_o)
	);

	always #(CLK_HALF_NS) pll_afi_clk = ~pll_afi_clk;

	// ****************************************
	// Failure reporting and compare tasks
	// ****************************************

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "Stopped at the first error");
	endtask

	// Write responses carry no defined read data, so prdata is optional
	task automatic check_apb_rsp(input string name, input rdp_pkg::apb_rsp_t exp,
		input rdp_pkg::apb_rsp_t act, input logic cmp_data);
		if ((act.pready !== exp.pready) || (act.pslverr !== exp.pslverr) ||
			(cmp_data && (act.prdata !== exp.prdata)))
			fail_now($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic compare_rdata(input string name,
		input logic [rdp_pkg::AFI_DATA_WIDTH-1:0] exp,
		input logic [rdp_pkg::AFI_DATA_WIDTH-1:0] act);
		if (act !== exp)
			fail_now($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic expect_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_now($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic expect_dqs_enable(input string name,
		input logic [rdp_pkg::NUM_GROUPS-1:0] exp,
		input logic [rdp_pkg::NUM_GROUPS-1:0] act);
		if (act !== exp)
			fail_now($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
	endtask

	// ****************************************
	// Reference model from the timing rules
	// ****************************************

	function automatic logic req_at(input int idx);
		if ((idx >= 0) && (idx < en_log.size()))
			return en_log[idx];
		return 1'b0;
	endfunction

	// The n-th read since a FIFO reset returns the newest word held in slot n mod 8
	function automatic logic [rdp_pkg::AFI_DATA_WIDTH-1:0] fifo_word(input int n,
		input int last_idx);
		int idx;
		idx = fifo_base + (n % rdp_pkg::READ_FIFO_DEPTH);
		while (idx + rdp_pkg::READ_FIFO_DEPTH <= last_idx)
			idx = idx + rdp_pkg::READ_FIFO_DEPTH;
		return dq_log[idx];
	endfunction

	// Group g holds {T1, T0} at bit 16g, the AFI word puts both T1 bytes on top
	function automatic logic [rdp_pkg::AFI_DATA_WIDTH-1:0] slot_order(
		input logic [rdp_pkg::AFI_DATA_WIDTH-1:0] grp);
		return {grp[31:24], grp[15:8], grp[23:16], grp[7:0]};
	endfunction

	// Called mid-cycle after the drive of log entry d, the cycle after edge d
	task automatic check_cycle(input string name);
		int d;
		logic exp_valid;
		logic exp_oct_off;
		logic [rdp_pkg::NUM_GROUPS-1:0] exp_dqs;
		d = en_log.size() - 1;
		// A request driven at d_r is sampled at E = d_r + 1, valid follows edge E+L+1
		exp_valid = req_at(d - cur_lat - 2);
		expect_bit({name, " valid"}, exp_valid, afi_rdata_valid_o);
		if (exp_valid)
		begin
			// The read edge is d, so only words driven up to d-2 are stored by then
			compare_rdata({name, " rdata"}, slot_order(fifo_word(rd_count, d - 2)),
				afi_rdata_o);
			rd_count++;
		end
		// DQS enable follows edge E+A+2 for each group
		for (int g = 0; g < rdp_pkg::NUM_GROUPS; g++)
			exp_dqs[g] = req_at(d - vfifo_addr[g] - 3);
		expect_dqs_enable({name, " dqs_enable"}, exp_dqs, dqs_enable_ctrl_o);
		// Termination is released after edges E+ON+1 through E+OFF+1
		exp_oct_off = 1'b1;
		for (int k = rdp_pkg::OCT_ON_DELAY + 2; k <= rdp_pkg::OCT_OFF_DELAY + 2; k++)
			if (req_at(d - k))
				exp_oct_off = 1'b0;
		expect_bit({name, " force_oct_off"}, exp_oct_off, force_oct_off_o);
	endtask

	// ****************************************
	// Drivers
	// ****************************************

	// Every edge gets a fresh DDIO word, the FIFO writes one each cycle
	task automatic drive_edge(input string name, input logic en,
		input rdp_pkg::apb_req_t req);
		logic [rdp_pkg::AFI_DATA_WIDTH-1:0] word;
		@(posedge pll_afi_clk);
		word = rdp_pkg::AFI_DATA_WIDTH'($random(seed));
		apb_req_i <= req;
		afi_rdata_en_full_i <= en;
		ddio_phy_dq_i <= word;
		en_log.push_back(en);
		dq_log.push_back(word);
		@(negedge pll_afi_clk);
		check_cycle(name);
	endtask

	task automatic idle_cycles(input string name, input int n);
		repeat (n)
			drive_edge(name, 1'b0, '0);
	endtask

	// Setup, access and a trailing idle edge, the access edge is the third one
	task automatic apb_write(input string name,
		input logic [rdp_pkg::APB_ADDR_WIDTH-1:0] addr,
		input logic [rdp_pkg::APB_DATA_WIDTH-1:0] data, input logic exp_err);
		rdp_pkg::apb_req_t req;
		rdp_pkg::apb_rsp_t exp_rsp;
		req = '0;
		req.psel = 1'b1;
		req.pwrite = 1'b1;
		req.paddr = addr;
		req.pwdata = data;
		drive_edge(name, 1'b0, req);
		req.penable = 1'b1;
		drive_edge(name, 1'b0, req);
		exp_rsp = '0;
		exp_rsp.pready = 1'b1;
		exp_rsp.pslverr = exp_err;
		check_apb_rsp({name, " write response"}, exp_rsp, apb_rsp_o, 1'b0);
		drive_edge(name, 1'b0, '0);
	endtask

	task automatic apb_read(input string name,
		input logic [rdp_pkg::APB_ADDR_WIDTH-1:0] addr,
		input logic [rdp_pkg::APB_DATA_WIDTH-1:0] exp_data, input logic exp_err);
		rdp_pkg::apb_req_t req;
		rdp_pkg::apb_rsp_t exp_rsp;
		req = '0;
		req.psel = 1'b1;
		req.paddr = addr;
		drive_edge(name, 1'b0, req);
		req.penable = 1'b1;
		drive_edge(name, 1'b0, req);
		exp_rsp.prdata = exp_data;
		exp_rsp.pready = 1'b1;
		exp_rsp.pslverr = exp_err;
		// An error read has no defined data
		check_apb_rsp({name, " read response"}, exp_rsp, apb_rsp_o, ~exp_err);
		drive_edge(name, 1'b0, '0);
	endtask

	`include "tb_tests.svh"

	// ****************************************
	// Sequence and watchdog
	// ****************************************

	initial
	begin
		pll_afi_clk = 1'b0;
		reset_n_afi_clk = 1'b0;
		apb_req_i = '0;
		afi_rdata_en_full_i = 1'b0;
		ddio_phy_dq_i = '0;
		for (int g = 0; g < rdp_pkg::NUM_GROUPS; g++)
			vfifo_addr[g] = 0;
		repeat (3) @(posedge pll_afi_clk);
		reset_n_afi_clk <= 1'b1;
		reset_defaults();
		latency_bursts();
		irregular_requests();
		vfifo_steps();
		oct_window();
		$display("** PASS **");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		fail_now("Timeout: the tests did not finish within the watchdog limit");
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+bench
src/rdp_pkg.sv
src/rdp_calib_regs.sv
src/rdp_latency_pipe.sv
src/rdp_valid_predict.sv
src/rdp_read_fifo.sv
src/rdp_read_datapath.sv
bench/tb_read_datapath.sv
